/* common/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

////////////////////////////////////////
// Datapath width
////////////////////////////////////////

`define XLEN 64

////////////////////////////////////////
// Operand select vector
////////////////////////////////////////

`define OP_SEL_W        3
`define OP_SEL_IMM_SEXT 0
`define OP_SEL_IMM_ZEXT 1
`define OP_SEL_RF       2

////////////////////////////////////////
// One-hot unit select vector
////////////////////////////////////////

`define ALU_OPW    7
`define ALU_OP_ADD 0
`define ALU_OP_SUB 1
`define ALU_OP_AND 2
`define ALU_OP_OR  3
`define ALU_OP_XOR 4
`define ALU_OP_SLL 5
`define ALU_OP_SRL 6

`define DMEM_WORDS 64 // 512 bytes.
`define DMEM_AW    6

`endif

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

   typedef enum logic [6:0] {
      OP_IMM = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011
   } opcode_e;

   typedef logic [2:0] funct3_t;

   localparam funct3_t F3_ADDI = 3'b000;
   localparam funct3_t F3_B    = 3'b000;
   localparam funct3_t F3_H    = 3'b001;
   localparam funct3_t F3_W    = 3'b010;
   localparam funct3_t F3_D    = 3'b011;
   localparam funct3_t F3_BU   = 3'b100;
   localparam funct3_t F3_HU   = 3'b101;
   localparam funct3_t F3_WU   = 3'b110;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      funct3_t     funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      funct3_t     funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
   } s_fmt_t;

   // The same 32 bits seen as either format.
   typedef union packed {
      i_fmt_t i;
      s_fmt_t s;
   } insn_u;

endpackage

`default_nettype wire

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

   typedef logic [3:0] lsu_size_t; // Access size in bytes.

   localparam lsu_size_t SIZE_B = 4'd1;
   localparam lsu_size_t SIZE_H = 4'd2;
   localparam lsu_size_t SIZE_W = 4'd4;
   localparam lsu_size_t SIZE_D = 4'd8;

   typedef enum logic {
      WB_ALU = 1'b0,
      WB_LSU = 1'b1
   } wb_sel_e;

endpackage

`default_nettype wire

/* source/idu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module idu
   import isa_pkg::*;
   import core_pkg::*;
(
   input  logic [31:0]           i_insn,
   output logic                  o_legal,
   output logic                  o_rf_we,
   output logic [4:0]            o_rd,
   output logic [4:0]            o_rs1_addr,
   output logic [4:0]            o_rs2_addr,
   output logic [`OP_SEL_W-1:0]  o_op_sel,
   output logic [`ALU_OPW-1:0]   o_fu_sel,
   output logic                  o_lsu_load,
   output logic                  o_lsu_store,
   output logic                  o_lsu_sigext,
   output lsu_size_t             o_lsu_size,
   output wb_sel_e               o_wb_sel,
   output logic [11:0]           o_imm12
);

   insn_u insn;
   logic  is_op_imm;
   logic  is_load;
   logic  is_store;
   logic  op_addi;
   logic  op_lb, op_lh, op_lw, op_ld;
   logic  op_lbu, op_lhu, op_lwu;
   logic  op_sb, op_sh, op_sw, op_sd;

   assign insn = i_insn;

   assign is_op_imm = (insn.i.opcode == OP_IMM);
   assign is_load   = (insn.i.opcode == LOAD);
   assign is_store  = (insn.i.opcode == STORE);

   ////////////////////////////////////////
   // One-hot instruction flags
   ////////////////////////////////////////

   assign op_addi = is_op_imm & (insn.i.funct3 == F3_ADDI);

   assign op_lb  = is_load & (insn.i.funct3 == F3_B);
   assign op_lh  = is_load & (insn.i.funct3 == F3_H);
   assign op_lw  = is_load & (insn.i.funct3 == F3_W);
   assign op_ld  = is_load & (insn.i.funct3 == F3_D);
   assign op_lbu = is_load & (insn.i.funct3 == F3_BU);
   assign op_lhu = is_load & (insn.i.funct3 == F3_HU);
   assign op_lwu = is_load & (insn.i.funct3 == F3_WU);

   assign op_sb = is_store & (insn.s.funct3 == F3_B);
   assign op_sh = is_store & (insn.s.funct3 == F3_H);
   assign op_sw = is_store & (insn.s.funct3 == F3_W);
   assign op_sd = is_store & (insn.s.funct3 == F3_D);

   ////////////////////////////////////////
   // Control fields
   ////////////////////////////////////////

   assign o_lsu_load  = op_lb | op_lh | op_lw | op_ld | op_lbu | op_lhu | op_lwu;
   assign o_lsu_store = op_sb | op_sh | op_sw | op_sd;
   assign o_legal     = op_addi | o_lsu_load | o_lsu_store;

   assign o_rf_we    = op_addi | o_lsu_load;
   assign o_rd       = insn.i.rd;
   assign o_rs1_addr = insn.i.rs1;
   assign o_rs2_addr = o_lsu_store ? insn.s.rs2 : 5'd0; // Only stores read rs2.

   assign o_imm12 = is_store ? {insn.s.imm_hi, insn.s.imm_lo} : insn.i.imm;

   // Every supported instruction adds rs1 and the sign-extended immediate.
   assign o_op_sel[`OP_SEL_IMM_SEXT] = o_legal;
   assign o_op_sel[`OP_SEL_IMM_ZEXT] = 1'b0;
   assign o_op_sel[`OP_SEL_RF]       = 1'b0;

   assign o_fu_sel[`ALU_OP_ADD] = o_legal; // Adder doubles as address generator.
   assign o_fu_sel[`ALU_OP_SUB] = 1'b0;
   assign o_fu_sel[`ALU_OP_AND] = 1'b0;
   assign o_fu_sel[`ALU_OP_OR]  = 1'b0;
   assign o_fu_sel[`ALU_OP_XOR] = 1'b0;
   assign o_fu_sel[`ALU_OP_SLL] = 1'b0;
   assign o_fu_sel[`ALU_OP_SRL] = 1'b0;

   assign o_lsu_size = (op_lb | op_lbu | op_sb) ? SIZE_B :
                       (op_lh | op_lhu | op_sh) ? SIZE_H :
                       (op_lw | op_lwu | op_sw) ? SIZE_W : SIZE_D;

   assign o_lsu_sigext = op_lb | op_lh | op_lw;

   assign o_wb_sel = o_lsu_load ? WB_LSU : WB_ALU;

endmodule

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module regfile (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  logic [4:0]       i_rs1_addr,
   input  logic [4:0]       i_rs2_addr,
   input  logic             i_we,
   input  logic [4:0]       i_wr_addr,
   input  logic [`XLEN-1:0] i_wr_data,
   output logic [`XLEN-1:0] o_rs1_data,
   output logic [`XLEN-1:0] o_rs2_data
);

   logic [`XLEN-1:0] regs [1:31]; // x0 has no storage.

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_wr_addr != 5'd0)) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // Returns the value being written this cycle when the addresses match.
   function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
      logic [`XLEN-1:0] data;
      if (addr == 5'd0) begin
         data = '0;
      end else if (i_we && (addr == i_wr_addr)) begin
         data = i_wr_data;
      end else begin
         data = regs[addr];
      end
      return data;
   endfunction

   always_comb begin
      o_rs1_data = read_port(i_rs1_addr);
      o_rs2_data = read_port(i_rs2_addr);
   end

   // The top level filters out rd == 0 before it drives the write port.
   a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_we |-> (i_wr_addr != 5'd0));

endmodule

`default_nettype wire

/* lsu/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module lsu
   import core_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_load,
   input  logic                 i_store,
   input  lsu_size_t            i_size,
   input  logic                 i_sigext,
   input  logic [`XLEN-1:0]     i_addr,
   input  logic [`XLEN-1:0]     i_st_data,
   output logic [`XLEN-1:0]     o_ld_data,
   output logic [`DMEM_AW-1:0]  o_mem_idx,
   output logic [7:0]           o_mem_be,
   output logic                 o_mem_we,
   output logic [`XLEN-1:0]     o_mem_wdata,
   input  logic [`XLEN-1:0]     i_mem_rdata
);

   logic [2:0]       offset;
   logic [7:0]       size_mask;
   logic [`XLEN-1:0] rd_shifted;
   logic [`XLEN-1:0] rd_ext;

   assign offset    = i_addr[2:0];
   assign o_mem_idx = i_addr[`DMEM_AW+2:3];

   ////////////////////////////////////////
   // Store path
   ////////////////////////////////////////

   always_comb begin
      case (i_size)
         SIZE_B:  size_mask = 8'h01;
         SIZE_H:  size_mask = 8'h03;
         SIZE_W:  size_mask = 8'h0f;
         default: size_mask = 8'hff;
      endcase
   end

   assign o_mem_we    = i_store;
   assign o_mem_be    = i_store ? (size_mask << offset) : 8'h00;
   assign o_mem_wdata = i_st_data << {offset, 3'b000}; // Move bytes into their lanes.

   ////////////////////////////////////////
   // Load path
   ////////////////////////////////////////

   assign rd_shifted = i_mem_rdata >> {offset, 3'b000};

   always_comb begin
      case (i_size)
         SIZE_B:  rd_ext = {{(`XLEN-8){i_sigext & rd_shifted[7]}}, rd_shifted[7:0]};
         SIZE_H:  rd_ext = {{(`XLEN-16){i_sigext & rd_shifted[15]}}, rd_shifted[15:0]};
         SIZE_W:  rd_ext = {{(`XLEN-32){i_sigext & rd_shifted[31]}}, rd_shifted[31:0]};
         default: rd_ext = rd_shifted;
      endcase
   end

   assign o_ld_data = i_load ? rd_ext : '0;

   // Misaligned accesses are not supported, so the decoder and the test
   // stimulus must never produce one.
   a_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_load || i_store) |-> ((offset & (i_size[2:0] - 3'd1)) == 3'd0));

   a_one_op: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_load && i_store));

endmodule

`default_nettype wire

/* lsu/dmem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module dmem (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic [`DMEM_AW-1:0]  i_idx,
   input  logic [7:0]           i_be,
   input  logic                 i_we,
   input  logic [`XLEN-1:0]     i_wdata,
   output logic [`XLEN-1:0]     o_rdata
);

   logic [`XLEN-1:0] mem [0:`DMEM_WORDS-1];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int w = 0; w < `DMEM_WORDS; w++) begin
            mem[w] <= '0;
         end
      end else if (i_we) begin
         for (int b = 0; b < 8; b++) begin
            if (i_be[b]) begin
               mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
            end
         end
      end
   end

   assign o_rdata = mem[i_idx]; // Asynchronous read.

endmodule

`default_nettype wire

/* source/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_top
   import core_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  logic             i_insn_valid,
   input  logic [31:0]      i_insn,
   output logic             o_wb_valid,
   output logic [4:0]       o_wb_rd,
   output logic [`XLEN-1:0] o_wb_data,
   output logic             o_store_valid,
   output logic [`XLEN-1:0] o_store_addr,
   output logic             o_illegal
);

   logic                 legal;
   logic                 dec_rf_we;
   logic [4:0]           dec_rd;
   logic [4:0]           rs1_addr;
   logic [4:0]           rs2_addr;
   logic [`OP_SEL_W-1:0] op_sel;
   logic [`ALU_OPW-1:0]  fu_sel;
   logic                 dec_load;
   logic                 dec_store;
   logic                 dec_sigext;
   lsu_size_t            dec_size;
   wb_sel_e              dec_wb_sel;
   logic [11:0]          imm12;
   logic [`XLEN-1:0]     rs1_data;
   logic [`XLEN-1:0]     rs2_data;
   logic [`XLEN-1:0]     op_b;
   logic [`XLEN-1:0]     s1_sum;
   logic                 fire;

   logic                 s2_valid;
   logic                 s2_rf_we;
   logic                 s2_load;
   logic                 s2_store;
   logic [4:0]           s2_rd;
   lsu_size_t            s2_size;
   logic                 s2_sigext;
   wb_sel_e              s2_wb_sel;
   logic [`XLEN-1:0]     s2_sum;
   logic [`XLEN-1:0]     s2_rs2;

   logic                 rf_we;
   logic                 ld_req;
   logic                 st_req;
   logic [`XLEN-1:0]     ld_data;
   logic [`XLEN-1:0]     wb_data;
   logic [`DMEM_AW-1:0]  mem_idx;
   logic [7:0]           mem_be;
   logic                 mem_we;
   logic [`XLEN-1:0]     mem_wdata;
   logic [`XLEN-1:0]     mem_rdata;

   ////////////////////////////////////////
   // Stage 1: decode, read, add
   ////////////////////////////////////////

   idu u_idu (
      .i_insn       (i_insn),
      .o_legal      (legal),
      .o_rf_we      (dec_rf_we),
      .o_rd         (dec_rd),
      .o_rs1_addr   (rs1_addr),
      .o_rs2_addr   (rs2_addr),
      .o_op_sel     (op_sel),
      .o_fu_sel     (fu_sel),
      .o_lsu_load   (dec_load),
      .o_lsu_store  (dec_store),
      .o_lsu_sigext (dec_sigext),
      .o_lsu_size   (dec_size),
      .o_wb_sel     (dec_wb_sel),
      .o_imm12      (imm12)
   );

   regfile u_regfile (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_we       (rf_we),
      .i_wr_addr  (s2_rd),
      .i_wr_data  (wb_data),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data)
   );

   // AND-OR mux over the one-hot operand select.
   assign op_b = ({`XLEN{op_sel[`OP_SEL_IMM_SEXT]}} & {{(`XLEN-12){imm12[11]}}, imm12})
               | ({`XLEN{op_sel[`OP_SEL_IMM_ZEXT]}} & {{(`XLEN-12){1'b0}}, imm12})
               | ({`XLEN{op_sel[`OP_SEL_RF]}} & rs2_data);

   assign s1_sum = {`XLEN{fu_sel[`ALU_OP_ADD]}} & (rs1_data + op_b);

   assign fire = i_insn_valid & legal;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         s2_valid  <= 1'b0;
         s2_rf_we  <= 1'b0;
         s2_load   <= 1'b0;
         s2_store  <= 1'b0;
         o_illegal <= 1'b0;
      end else begin
         s2_valid  <= fire;
         o_illegal <= i_insn_valid & ~legal;
         if (fire) begin
            s2_rf_we <= dec_rf_we;
            s2_load  <= dec_load;
            s2_store <= dec_store;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (fire) begin
         s2_rd     <= dec_rd;
         s2_size   <= dec_size;
         s2_sigext <= dec_sigext;
         s2_wb_sel <= dec_wb_sel;
         s2_sum    <= s1_sum;
         s2_rs2    <= rs2_data;
      end
   end

   ////////////////////////////////////////
   // Stage 2: memory and write-back
   ////////////////////////////////////////

   assign ld_req = s2_valid & s2_load;
   assign st_req = s2_valid & s2_store;
   assign rf_we  = s2_valid & s2_rf_we & (s2_rd != 5'd0);

   lsu u_lsu (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_load      (ld_req),
      .i_store     (st_req),
      .i_size      (s2_size),
      .i_sigext    (s2_sigext),
      .i_addr      (s2_sum),
      .i_st_data   (s2_rs2),
      .o_ld_data   (ld_data),
      .o_mem_idx   (mem_idx),
      .o_mem_be    (mem_be),
      .o_mem_we    (mem_we),
      .o_mem_wdata (mem_wdata),
      .i_mem_rdata (mem_rdata)
   );

   dmem u_dmem (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_idx   (mem_idx),
      .i_be    (mem_be),
      .i_we    (mem_we),
      .i_wdata (mem_wdata),
      .o_rdata (mem_rdata)
   );

   assign wb_data = (s2_wb_sel == WB_LSU) ? ld_data : s2_sum;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wb_valid    <= 1'b0;
         o_store_valid <= 1'b0;
      end else begin
         o_wb_valid    <= rf_we;
         o_store_valid <= st_req;
      end
   end

   always_ff @(posedge i_clk) begin
      if (rf_we) begin
         o_wb_rd   <= s2_rd;
         o_wb_data <= wb_data;
      end
      if (st_req) begin
         o_store_addr <= s2_sum;
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core;

   localparam int PERIOD     = 40;
   localparam int DRIVE_DLY  = 5;
   localparam int RST_CYC    = 16;
   localparam int N_DIRECTED = 40;
   localparam int N_RANDOM   = 200;
   localparam int N_INSN     = N_DIRECTED + N_RANDOM;

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   logic        i_clk;
   logic        i_rst_n;
   logic        i_insn_valid;
   logic [31:0] i_insn;
   logic        o_wb_valid;
   logic [4:0]  o_wb_rd;
   logic [63:0] o_wb_data;
   logic        o_store_valid;
   logic [63:0] o_store_addr;
   logic        o_illegal;

   integer      seed;
   int          probe_addr [0:3] = '{67, 74, 84, 88}; // One aligned slot per size.

   logic [63:0] ref_regs [0:31];
   logic [7:0]  ref_mem [0:511];

   logic        nxt_wb_v;    // Expectation of the instruction driven now.
   logic [4:0]  nxt_wb_rd;
   logic [63:0] nxt_wb_data;
   logic        nxt_st_v;
   logic [63:0] nxt_st_addr;
   logic        nxt_ill;

   logic        ill_q;
   logic        wb1_v, wb2_v;
   logic [4:0]  wb1_rd, wb2_rd;
   logic [63:0] wb1_data, wb2_data;
   logic        st1_v, st2_v;
   logic [63:0] st1_addr, st2_addr;

   core_top dut0 (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_insn_valid  (i_insn_valid),
      .i_insn        (i_insn),
      .o_wb_valid    (o_wb_valid),
      .o_wb_rd       (o_wb_rd),
      .o_wb_data     (o_wb_data),
      .o_store_valid (o_store_valid),
      .o_store_addr  (o_store_addr),
      .o_illegal     (o_illegal)
   );

   initial begin
      i_clk = 1'b0;
      forever #(PERIOD/2) i_clk = ~i_clk;
   end

   ////////////////////////////////////////
   // Expected outputs and checks
   ////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ill_q    <= 1'b0;
         wb1_v    <= 1'b0;
         wb1_rd   <= '0;
         wb1_data <= '0;
         wb2_v    <= 1'b0;
         wb2_rd   <= '0;
         wb2_data <= '0;
         st1_v    <= 1'b0;
         st1_addr <= '0;
         st2_v    <= 1'b0;
         st2_addr <= '0;
      end else begin
         ill_q    <= nxt_ill;     // Illegal shows one edge after sampling.
         wb1_v    <= nxt_wb_v;
         wb1_rd   <= nxt_wb_rd;
         wb1_data <= nxt_wb_data;
         wb2_v    <= wb1_v;       // Retirement shows two edges after sampling.
         wb2_rd   <= wb1_rd;
         wb2_data <= wb1_data;
         st1_v    <= nxt_st_v;
         st1_addr <= nxt_st_addr;
         st2_v    <= st1_v;
         st2_addr <= st1_addr;
      end
   end

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic value_error(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      abort_run();
   endtask

   a_reset_quiet: assert property (@(posedge i_clk)
      !i_rst_n |-> (!o_wb_valid && !o_store_valid && !o_illegal))
      else value_error("o_wb_valid/o_store_valid/o_illegal", 64'd0,
         {$sampled(o_wb_valid), $sampled(o_store_valid), $sampled(o_illegal)});

   a_wb_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_wb_valid == wb2_v)
      else value_error("o_wb_valid", $sampled(wb2_v), $sampled(o_wb_valid));

   a_wb_rd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      wb2_v |-> (o_wb_rd == wb2_rd))
      else value_error("o_wb_rd", $sampled(wb2_rd), $sampled(o_wb_rd));

   a_wb_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      wb2_v |-> (o_wb_data == wb2_data))
      else value_error("o_wb_data", $sampled(wb2_data), $sampled(o_wb_data));

   a_store_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_store_valid == st2_v)
      else value_error("o_store_valid", $sampled(st2_v), $sampled(o_store_valid));

   a_store_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      st2_v |-> (o_store_addr == st2_addr))
      else value_error("o_store_addr", $sampled(st2_addr), $sampled(o_store_addr));

   a_illegal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_illegal == ill_q)
      else value_error("o_illegal", $sampled(ill_q), $sampled(o_illegal));

   initial begin
      #((RST_CYC + N_INSN + 10) * PERIOD);
      $display("The run timed out after %0d clock periods.", RST_CYC + N_INSN + 10);
      abort_run();
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic logic legal_enc(input logic [31:0] w);
      logic [2:0] f3;
      f3 = w[14:12];
      return ((w[6:0] == OPC_OP_IMM) && (f3 == 3'b000))
          || ((w[6:0] == OPC_LOAD) && (f3 != 3'b111))
          || ((w[6:0] == OPC_STORE) && !f3[2]);
   endfunction

   function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
   endfunction

   task automatic clear_expect();
      nxt_wb_v    = 1'b0;
      nxt_wb_rd   = '0;
      nxt_wb_data = '0;
      nxt_st_v    = 1'b0;
      nxt_st_addr = '0;
      nxt_ill     = 1'b0;
   endtask

   // Runs one instruction in program order on the model state.
   task automatic model_insn(input logic [31:0] w);
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [63:0] imm_i;
      logic [63:0] imm_s;
      logic [63:0] addr;
      logic [63:0] res;
      int          nbytes;
      rd     = w[11:7];
      rs1    = w[19:15];
      rs2    = w[24:20];
      f3     = w[14:12];
      imm_i  = {{52{w[31]}}, w[31:20]};
      imm_s  = {{52{w[31]}}, w[31:25], w[11:7]};
      nbytes = 1 << f3[1:0];
      clear_expect();
      if (!legal_enc(w)) begin
         nxt_ill = 1'b1;
      end else if (w[6:0] == OPC_STORE) begin
         addr = ref_regs[rs1] + imm_s;
         for (int i = 0; i < nbytes; i++) begin
            ref_mem[addr[8:0] + i] = ref_regs[rs2][8*i +: 8];
         end
         nxt_st_v    = 1'b1;
         nxt_st_addr = addr;
      end else begin
         if (w[6:0] == OPC_OP_IMM) begin
            res = ref_regs[rs1] + imm_i;
         end else begin
            addr = ref_regs[rs1] + imm_i;
            res  = '0;
            for (int i = 0; i < nbytes; i++) begin
               res[8*i +: 8] = ref_mem[addr[8:0] + i];
            end
            if (!f3[2]) begin
               for (int b = 8*nbytes; b < 64; b++) begin
                  res[b] = res[8*nbytes-1];
               end
            end
         end
         if (rd != 5'd0) begin
            ref_regs[rd] = res;
            nxt_wb_v     = 1'b1;
            nxt_wb_rd    = rd;
            nxt_wb_data  = res;
         end
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   task automatic step();
      @(posedge i_clk);
      #DRIVE_DLY;
   endtask

   task automatic issue(input logic [31:0] w);
      i_insn_valid = 1'b1;
      i_insn       = w;
      model_insn(w);
      step();
   endtask

   task automatic idle();
      i_insn_valid = 1'b0;
      i_insn       = $random(seed); // Ignored without the strobe.
      clear_expect();
      step();
   endtask

   // Picks a base register and an immediate that reach the byte address a.
   task automatic split_addr(input int a, output logic [4:0] rs1, output logic [11:0] imm);
      logic signed [63:0] diff;
      rs1  = 5'({$random(seed)} % 16);
      diff = 64'(a) - ref_regs[rs1];
      if ((diff >= -2048) && (diff <= 2047)) begin
         imm = diff[11:0];
      end else begin
         rs1 = 5'd0;
         imm = 12'(a);
      end
   endtask

   task automatic rand_addr(input int nbytes, output int a);
      a = ({$random(seed)} % 128) & ~(nbytes - 1);
   endtask

   task automatic addi_to(input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
      issue(enc_i(OPC_OP_IMM, 3'b000, rd, rs1, imm));
   endtask

   task automatic load_from(input logic [2:0] f3, input logic [4:0] rd, input int a);
      logic [4:0]  rs1;
      logic [11:0] imm;
      split_addr(a, rs1, imm);
      issue(enc_i(OPC_LOAD, f3, rd, rs1, imm));
   endtask

   task automatic store_to(input logic [2:0] f3, input logic [4:0] rs2, input int a);
      logic [4:0]  rs1;
      logic [11:0] imm;
      split_addr(a, rs1, imm);
      issue(enc_s(f3, rs1, rs2, imm));
   endtask

   initial begin
      int          kind;
      int          a;
      logic [2:0]  f3;
      logic [4:0]  rd;
      logic [31:0] w;
      seed         = 25496;
      i_rst_n      = 1'b1;
      i_insn_valid = 1'b0;
      i_insn       = '0;
      clear_expect();
      for (int r = 0; r < 32; r++) begin
         ref_regs[r] = '0;
      end
      for (int m = 0; m < 512; m++) begin
         ref_mem[m] = '0;
      end
      #1 i_rst_n = 1'b0; // Clean falling edge before the first clock.
      repeat (RST_CYC) @(posedge i_clk);
      #DRIVE_DLY i_rst_n = 1'b1;

      addi_to(5'd1, 5'd0, 12'd100);
      addi_to(5'd2, 5'd1, 12'hff9); // Reads x1 in the cycle after it was sampled.
      addi_to(5'd3, 5'd0, 12'h800);
      addi_to(5'd4, 5'd3, 12'h1a5);
      idle();
      for (int s = 0; s < 4; s++) begin
         store_to(3'(s), 5'd4, probe_addr[s]);
      end
      for (int s = 0; s < 4; s++) begin
         load_from(3'(s), 5'(5 + s), probe_addr[s]);
      end
      for (int s = 0; s < 3; s++) begin
         load_from(3'(4 + s), 5'(9 + s), probe_addr[s]);
      end
      load_from(3'd3, 5'd12, 88);
      addi_to(5'd13, 5'd12, 12'd1); // Load result used at once.
      store_to(3'd3, 5'd12, 96);
      load_from(3'd3, 5'd14, 96);
      idle();
      addi_to(5'd0, 5'd4, 12'd5);
      load_from(3'd3, 5'd0, 88);
      addi_to(5'd15, 5'd0, 12'd0);
      idle();
      issue(enc_i(OPC_OP, 3'b000, 5'd5, 5'd1, 12'd0));
      issue(enc_i(OPC_OP_IMM, 3'b001, 5'd6, 5'd1, 12'd3));
      issue(enc_i(OPC_LOAD, 3'b111, 5'd7, 5'd0, 12'd88));
      issue(enc_s(3'b100, 5'd0, 5'd1, 12'd88));
      addi_to(5'd15, 5'd5, 12'd0);
      load_from(3'd3, 5'd16, 88);
      store_to(3'd3, 5'd4, 504);
      load_from(3'd2, 5'd17, 508);
      idle();

      for (int k = 0; k < N_RANDOM; k++) begin
         kind = {$random(seed)} % 16;
         rd   = 5'({$random(seed)} % 16);
         if (kind < 5) begin
            addi_to(rd, 5'({$random(seed)} % 16), 12'($random(seed)));
         end else if (kind < 9) begin
            f3 = 3'({$random(seed)} % 4);
            rand_addr(1 << f3, a);
            store_to(f3, 5'({$random(seed)} % 16), a);
         end else if (kind < 13) begin
            f3 = 3'({$random(seed)} % 7);
            rand_addr(1 << f3[1:0], a);
            load_from(f3, rd, a);
         end else if (kind < 15) begin
            w = $random(seed);
            while (legal_enc(w)) begin
               w = $random(seed);
            end
            issue(w);
         end else begin
            idle();
         end
      end
      repeat (4) idle();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
source/idu.sv
source/regfile.sv
lsu/lsu.sv
lsu/dmem.sv
source/core_top.sv
testbench/tb_core.sv

/* Bender.yml */
package:
  name: rv64_ls_datapath

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/core_pkg.sv
      - source/idu.sv
      - source/regfile.sv
      - lsu/lsu.sv
      - lsu/dmem.sv
      - source/core_top.sv
  - target: test
    files:
      - testbench/tb_core.sv
